/* logic/acq_pkg.sv */
`default_nettype none

////////////////////////////////
// acquisition front end constants
////////////////////////////////
package acq_pkg;

	// preamp gain codes, one nibble per channel
	localparam logic [3:0] GAIN_A = 4'b1000;
	localparam logic [3:0] GAIN_B = 4'b0001;

	// preamp spi frame, one gain word
	localparam int AMP_BITS = 8;

	// adc sample width and frame length in sck periods
	// 2 idle, 14 of A, 2 idle, 14 of B, 2 idle
	localparam int ADC_BITS = 14;
	localparam int ADC_FRAME = 34;

	// clock cycles between conversion starts
	localparam int SAMPLE_DIV = 100;

	// hold-off between two preamp frames
	localparam int HOLD_CYCLES = 50;

	// led patterns
	localparam logic [7:0] LED_RESET = 8'haa;
	localparam logic [7:0] LED_DEFAULT = 8'h55;

	// switch codes for the led source
	localparam logic [3:0] SW_A_LO = 4'h1;
	localparam logic [3:0] SW_A_HI = 4'h2;
	localparam logic [3:0] SW_B_LO = 4'h4;
	localparam logic [3:0] SW_B_HI = 4'h8;
	// amplifier readback
	localparam logic [3:0] SW_AMP = 4'h3;

endpackage

`default_nettype wire

/* logic/sample_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_timer (
	input logic CLK50MHZ,
	input logic RST,
	output logic sample_start
);
	import acq_pkg::*;

	// divider width and wrap value
	localparam int CNT_W = $clog2(SAMPLE_DIV);
	localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(SAMPLE_DIV - 1);

	logic [CNT_W-1:0] div_cnt;

	////////////////////////////////
	// free running divider
	////////////////////////////////
	// first strobe SAMPLE_DIV cycles after reset
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			div_cnt <= '0;
			sample_start <= 1'b0;
		end else if (div_cnt == DIV_LAST) begin
			// wrap, one cycle start strobe
			div_cnt <= '0;
			sample_start <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			sample_start <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* logic/preamp_spi.sv */
`timescale 1ns/1ps
`default_nettype none

module preamp_spi (
	input logic CLK50MHZ,
	input logic RST,
	input logic amp_trig,
	output logic amp_done,
	output logic [acq_pkg::AMP_BITS-1:0] amp_rx,
	output logic amp_cs,
	output logic amp_sck,
	output logic amp_mosi,
	input logic amp_miso
);
	import acq_pkg::*;

	// gain word, channel B in the high nibble
	localparam logic [AMP_BITS-1:0] AMP_WORD = {GAIN_B, GAIN_A};
	localparam int BIT_W = $clog2(AMP_BITS);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(AMP_BITS - 1);

	logic busy;
	logic [BIT_W-1:0] bit_cnt;
	// tx and rx shifters
	logic [AMP_BITS-1:0] tx_sr;
	logic [AMP_BITS-1:0] rx_sr;

	// msb first out of the tx shifter
	assign amp_mosi = tx_sr[AMP_BITS-1];

	////////////////////////////////
	// frame control
	////////////////////////////////
	// sck low half puts a bit out, high half samples it
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			busy <= 1'b0;
			amp_cs <= 1'b1;
			amp_sck <= 1'b0;
			amp_done <= 1'b0;
			bit_cnt <= '0;
		end else begin
			amp_done <= 1'b0;
			if (!busy) begin
				// trigger opens the frame, cs low next cycle
				if (amp_trig) begin
					busy <= 1'b1;
					amp_cs <= 1'b0;
					bit_cnt <= '0;
				end
			end else if (!amp_sck) begin
				// rising sck
				amp_sck <= 1'b1;
			end else begin
				// falling sck, next bit or end of frame
				amp_sck <= 1'b0;
				if (bit_cnt == LAST_BIT) begin
					busy <= 1'b0;
					amp_cs <= 1'b1;
					amp_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////////////////
	// data path
	////////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (!busy && amp_trig) begin
			tx_sr <= AMP_WORD;
		end else if (busy && amp_sck) begin
			tx_sr <= {tx_sr[AMP_BITS-2:0], 1'b0};
		end
		// miso taken together with the rising sck
		if (busy && !amp_sck) begin
			rx_sr <= {rx_sr[AMP_BITS-2:0], amp_miso};
		end
		// readback held steady until the next frame ends
		if (busy && amp_sck && bit_cnt == LAST_BIT) begin
			amp_rx <= rx_sr;
		end
	end

endmodule

`default_nettype wire

/* logic/adc_spi.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_spi (
	input logic CLK50MHZ,
	input logic RST,
	input logic sample_start,
	output logic adc_done,
	output logic [acq_pkg::ADC_BITS-1:0] sample_a,
	output logic [acq_pkg::ADC_BITS-1:0] sample_b,
	output logic adc_conv,
	output logic adc_sck,
	input logic adc_miso
);
	import acq_pkg::*;

	// slot numbering from 0, one slot per sck period
	localparam int SLOT_W = $clog2(ADC_FRAME);
	localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(ADC_FRAME - 1);
	localparam logic [SLOT_W-1:0] A_FIRST = SLOT_W'(2);
	localparam logic [SLOT_W-1:0] A_LAST = SLOT_W'(1 + ADC_BITS);
	localparam logic [SLOT_W-1:0] B_FIRST = SLOT_W'(4 + ADC_BITS);
	localparam logic [SLOT_W-1:0] B_LAST = SLOT_W'(3 + 2 * ADC_BITS);

	logic busy;
	logic [SLOT_W-1:0] slot;
	logic in_a;
	logic in_b;
	logic [ADC_BITS-1:0] shift_a;
	logic [ADC_BITS-1:0] shift_b;

	// which channel the current slot belongs to
	assign in_a = (slot >= A_FIRST) && (slot <= A_LAST);
	assign in_b = (slot >= B_FIRST) && (slot <= B_LAST);

	////////////////////////////////
	// conversion and sck sequencing
	////////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			busy <= 1'b0;
			adc_conv <= 1'b0;
			adc_sck <= 1'b0;
			adc_done <= 1'b0;
			slot <= '0;
		end else begin
			adc_conv <= 1'b0;
			adc_done <= 1'b0;
			if (!busy) begin
				// start while busy is dropped
				if (sample_start) begin
					busy <= 1'b1;
					adc_conv <= 1'b1;
					slot <= '0;
				end
			end else if (adc_conv) begin
				// conversion pulse cycle, sck still idle
				adc_sck <= 1'b0;
			end else if (!adc_sck) begin
				adc_sck <= 1'b1;
			end else begin
				adc_sck <= 1'b0;
				if (slot == SLOT_LAST) begin
					busy <= 1'b0;
					adc_done <= 1'b1;
				end else begin
					slot <= slot + 1'b1;
				end
			end
		end
	end

	////////////////////////////////
	// sample capture
	////////////////////////////////
	// bits taken at the rising sck, idle slots skipped
	always_ff @(posedge CLK50MHZ) begin
		if (busy && !adc_conv && !adc_sck) begin
			if (in_a) begin
				shift_a <= {shift_a[ADC_BITS-2:0], adc_miso};
			end
			if (in_b) begin
				shift_b <= {shift_b[ADC_BITS-2:0], adc_miso};
			end
		end
		// outputs move only at frame end
		if (busy && adc_sck && slot == SLOT_LAST) begin
			sample_a <= shift_a;
			sample_b <= shift_b;
		end
	end

endmodule

`default_nettype wire

/* logic/acq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_ctrl (
	input logic CLK50MHZ,
	input logic RST,
	input logic amp_done,
	output logic amp_trig,
	input logic adc_done,
	input logic [acq_pkg::ADC_BITS-1:0] sample_a,
	input logic [acq_pkg::ADC_BITS-1:0] sample_b,
	input logic [acq_pkg::AMP_BITS-1:0] amp_rx,
	input logic [3:0] sw,
	output logic [7:0] led
);
	import acq_pkg::*;

	// preamp sequencer states
	typedef enum logic [1:0] {
		RESTART,
		AMP_SENDING,
		CNT_WAIT
	} seq_state_t;

	localparam int HOLD_W = $clog2(HOLD_CYCLES);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(HOLD_CYCLES - 1);
	// zero fill for the high sample slices
	localparam int HI_PAD = 16 - ADC_BITS;

	seq_state_t state;
	logic [HOLD_W-1:0] hold_cnt;
	logic hold_end;

	////////////////////////////////
	// preamp sequencer
	////////////////////////////////
	// reset parks in CNT_WAIT at the last hold count
	// so the first frame goes out right away
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= CNT_WAIT;
		end else begin
			case (state)
				RESTART: state <= AMP_SENDING;
				AMP_SENDING: begin
					if (amp_done) begin
						state <= CNT_WAIT;
					end
				end
				CNT_WAIT: begin
					if (hold_end) begin
						state <= RESTART;
					end
				end
				default: state <= RESTART;
			endcase
		end
	end

	// hold-off counter, cleared outside CNT_WAIT
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			hold_cnt <= HOLD_LAST;
		end else if (state == CNT_WAIT && !hold_end) begin
			hold_cnt <= hold_cnt + 1'b1;
		end else begin
			hold_cnt <= '0;
		end
	end

	assign hold_end = (hold_cnt == HOLD_LAST);
	// one trigger per RESTART cycle
	assign amp_trig = (state == RESTART);

	////////////////////////////////
	// led latch
	////////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			led <= LED_RESET;
		end else if (adc_done) begin
			case (sw)
				SW_A_LO: led <= sample_a[7:0];
				SW_A_HI: led <= {{HI_PAD{1'b0}}, sample_a[ADC_BITS-1:8]};
				SW_B_LO: led <= sample_b[7:0];
				SW_B_HI: led <= {{HI_PAD{1'b0}}, sample_b[ADC_BITS-1:8]};
				// readback of the previous preamp frame
				SW_AMP: led <= amp_rx;
				default: led <= LED_DEFAULT;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/acq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_top (
	input logic CLK50MHZ,
	input logic RST,
	input logic [3:0] sw,
	output logic [7:0] led,
	// preamp pins
	output logic amp_cs,
	output logic amp_sck,
	output logic amp_mosi,
	input logic amp_miso,
	// adc pins
	output logic adc_conv,
	output logic adc_sck,
	input logic adc_miso,
	output logic sample_done
);
	import acq_pkg::*;

	logic sample_start;
	logic amp_trig;
	logic amp_done;
	logic [AMP_BITS-1:0] amp_rx;
	logic [ADC_BITS-1:0] sample_a;
	logic [ADC_BITS-1:0] sample_b;

	////////////////////////////////
	// sampling path
	////////////////////////////////
	sample_timer timer0 (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.sample_start(sample_start)
	);

	// adc done doubles as the board sample strobe
	adc_spi adc0 (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.sample_start(sample_start),
		.adc_done(sample_done),
		.sample_a(sample_a),
		.sample_b(sample_b),
		.adc_conv(adc_conv),
		.adc_sck(adc_sck),
		.adc_miso(adc_miso)
	);

	////////////////////////////////
	// preamp and control
	////////////////////////////////
	preamp_spi amp0 (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.amp_trig(amp_trig),
		.amp_done(amp_done),
		.amp_rx(amp_rx),
		.amp_cs(amp_cs),
		.amp_sck(amp_sck),
		.amp_mosi(amp_mosi),
		.amp_miso(amp_miso)
	);

	acq_ctrl ctrl0 (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.amp_done(amp_done),
		.amp_trig(amp_trig),
		.adc_done(sample_done),
		.sample_a(sample_a),
		.sample_b(sample_b),
		.amp_rx(amp_rx),
		.sw(sw),
		.led(led)
	);

endmodule

`default_nettype wire

/* verif/acq_props.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_props (
	input logic CLK50MHZ,
	input logic RST,
	input logic amp_cs,
	input logic amp_sck,
	input logic adc_conv,
	input logic sample_done
);
	import acq_pkg::*;

	// cycles amp_cs has been low in this frame
	int cs_low_cnt;

	always_ff @(posedge CLK50MHZ) begin
		if (RST || amp_cs) begin
			cs_low_cnt <= 0;
		end else begin
			cs_low_cnt <= cs_low_cnt + 1;
		end
	end

	// two clocks per preamp bit
	cs_frame_len: assert property (@(posedge CLK50MHZ) disable iff (RST)
		$rose(amp_cs) |-> cs_low_cnt == 2 * AMP_BITS)
		else $error("amp_cs low for %0d cycles", cs_low_cnt);

	// frame stuck with amp_cs low
	cs_frame_max: assert property (@(posedge CLK50MHZ) disable iff (RST)
		!amp_cs |-> cs_low_cnt < 2 * AMP_BITS)
		else $error("amp_cs low longer than %0d cycles", 2 * AMP_BITS);

	conv_width: assert property (@(posedge CLK50MHZ) disable iff (RST)
		adc_conv |=> !adc_conv)
		else $error("adc_conv wider than one cycle");

	conv_done_apart: assert property (@(posedge CLK50MHZ) disable iff (RST)
		!(sample_done && adc_conv))
		else $error("sample_done together with adc_conv");

	// sck parked low between frames
	sck_idle: assert property (@(posedge CLK50MHZ) disable iff (RST)
		amp_cs |-> !amp_sck)
		else $error("amp_sck high while amp_cs high");

endmodule

bind acq_top acq_props props0 (
	.CLK50MHZ(CLK50MHZ),
	.RST(RST),
	.amp_cs(amp_cs),
	.amp_sck(amp_sck),
	.adc_conv(adc_conv),
	.sample_done(sample_done)
);

`default_nettype wire

/* verif/acq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_tb;
	import acq_pkg::*;

	localparam int RST_CYCLES = 8;
	localparam int N_SAMPLES = 200;
	// 200 sample periods plus margin for reset and the last frame
	localparam int TIMEOUT_CYCLES = N_SAMPLES * SAMPLE_DIV + 5000;
	localparam logic [15:0] LFSR_SEED = 16'd69;
	// word the preamp must receive with the B nibble first
	localparam logic [7:0] GAIN_WORD = {GAIN_B, GAIN_A};
	// cs high gap between two preamp frames
	localparam int AMP_GAP = HOLD_CYCLES + 2;
	// conv pulse to frame done
	localparam int DONE_AFTER_CONV = 2 * ADC_FRAME + 1;

	// dut pins
	logic CLK50MHZ = 1'b0;
	logic RST = 1'b1;
	logic [3:0] sw = 4'h0;
	logic [7:0] led;
	logic amp_cs;
	logic amp_sck;
	logic amp_mosi;
	logic amp_miso = 1'b0;
	logic adc_conv;
	logic adc_sck;
	logic adc_miso = 1'b0;
	logic sample_done;

	logic [15:0] lfsr = LFSR_SEED;
	int cycle = 0;
	int checked = 0;
	// pin values seen on the previous tick
	logic cs_q = 1'b1;
	logic sck_q = 1'b0;
	logic adc_sck_q = 1'b0;
	logic conv_q = 1'b0;

	// preamp model state starts from zero contents
	logic [7:0] amp_sr = 8'h00;
	logic [7:0] amp_word = 8'h00;
	logic [7:0] rx_echo = 8'h00;
	logic [7:0] exp_rx = 8'h00;
	int amp_bits = 0;
	int amp_frames = 0;
	int rise_cycle = 0;

	// adc model state
	logic [ADC_FRAME-1:0] frame = '0;
	logic [ADC_BITS-1:0] cur_a = '0;
	logic [ADC_BITS-1:0] cur_b = '0;
	int conv_cycle = 0;
	int convs = 0;

	// led expectation for the next tick
	logic [7:0] led_exp = 8'h00;
	logic [3:0] sw_at_done = 4'h0;
	logic check_pending = 1'b0;

	acq_top dut0 (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.sw(sw),
		.led(led),
		.amp_cs(amp_cs),
		.amp_sck(amp_sck),
		.amp_mosi(amp_mosi),
		.amp_miso(amp_miso),
		.adc_conv(adc_conv),
		.adc_sck(adc_sck),
		.adc_miso(adc_miso),
		.sample_done(sample_done)
	);

	// 50 MHz
	always #10 CLK50MHZ = ~CLK50MHZ;

	//////////////////////////////
	// random source
	//////////////////////////////
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one lfsr step per bit taken
	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// mostly listed codes and now and then any code
	task automatic draw_switch;
		logic [31:0] pick;
		logic [31:0] code;
		random_bits(3, pick);
		case (pick[2:0])
			3'd0: sw = SW_A_LO;
			3'd1: sw = SW_A_HI;
			3'd2: sw = SW_B_LO;
			3'd3: sw = SW_B_HI;
			3'd4: sw = SW_AMP;
			default: begin
				random_bits(4, code);
				sw = code[3:0];
			end
		endcase
	endtask

	//////////////////////////////
	// reference model and reporting
	//////////////////////////////
	function automatic logic [7:0] led_choice(input logic [3:0] s,
			input logic [ADC_BITS-1:0] a, input logic [ADC_BITS-1:0] b,
			input logic [7:0] rx);
		logic [7:0] r;
		case (s)
			SW_A_LO: r = a[7:0];
			SW_A_HI: r = {2'b00, a[ADC_BITS-1:8]};
			SW_B_LO: r = b[7:0];
			SW_B_HI: r = {2'b00, b[ADC_BITS-1:8]};
			SW_AMP: r = rx;
			default: r = LED_DEFAULT;
		endcase
		return r;
	endfunction

	task automatic stop_run;
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic report_error(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		stop_run();
	endtask

	task automatic check_reset_state;
		assert (led == LED_RESET)
			else report_error($sformatf("led %02h in reset, expected %02h", led, LED_RESET));
		assert (amp_cs == 1'b1)
			else report_error("amp_cs low in reset");
		assert (adc_conv == 1'b0)
			else report_error("adc_conv high in reset");
	endtask

	//////////////////////////////
	// preamp device model
	//////////////////////////////
	task automatic preamp_model;
		if (cs_q && !amp_cs) begin
			// frame opens and echoes the last latched word
			if (amp_frames == 0) begin
				assert (cycle == RST_CYCLES + 2)
					else report_error($sformatf("first amp_cs fall at cycle %0d", cycle));
			end else begin
				assert (cycle - rise_cycle == AMP_GAP)
					else report_error($sformatf("amp_cs gap %0d cycles", cycle - rise_cycle));
			end
			amp_sr = amp_word;
			rx_echo = amp_word;
			amp_miso = amp_word[7];
			amp_bits = 0;
		end else if (!amp_cs && !sck_q && amp_sck) begin
			amp_sr = {amp_sr[6:0], amp_mosi};
			amp_bits = amp_bits + 1;
		end else if (!amp_cs && sck_q && !amp_sck) begin
			amp_miso = amp_sr[7];
		end
		if (!cs_q && amp_cs) begin
			// cs rising latches the word
			amp_word = amp_sr;
			assert (amp_bits == AMP_BITS)
				else report_error($sformatf("preamp frame had %0d sck edges", amp_bits));
			assert (amp_word == GAIN_WORD)
				else report_error($sformatf("gain word %02h, expected %02h",
					amp_word, GAIN_WORD));
			exp_rx = rx_echo;
			rise_cycle = cycle;
			amp_frames = amp_frames + 1;
		end
		// a missing amp_cs fall shows as cs held high too long
		if (amp_cs) begin
			if (amp_frames == 0) begin
				assert (cycle <= RST_CYCLES + 2)
					else report_error("first preamp frame did not start");
			end else begin
				assert (cycle - rise_cycle <= AMP_GAP)
					else report_error("amp_cs still high after the hold-off");
			end
		end
	endtask

	//////////////////////////////
	// adc device model and led check
	//////////////////////////////
	task automatic adc_model;
		logic [31:0] draw;
		if (check_pending) begin
			assert (led == led_exp)
				else report_error($sformatf("led %02h, expected %02h for sw %0h",
					led, led_exp, sw_at_done));
			checked = checked + 1;
			check_pending = 1'b0;
			draw_switch();
		end
		if (adc_conv && !conv_q) begin
			if (convs == 0) begin
				assert (cycle == RST_CYCLES + SAMPLE_DIV + 1)
					else report_error($sformatf("first adc_conv at cycle %0d", cycle));
			end else begin
				assert (cycle - conv_cycle == SAMPLE_DIV)
					else report_error($sformatf("adc_conv spacing %0d", cycle - conv_cycle));
			end
			random_bits(ADC_BITS, draw);
			cur_a = draw[ADC_BITS-1:0];
			random_bits(ADC_BITS, draw);
			cur_b = draw[ADC_BITS-1:0];
			// idle slots high so that a captured idle bit shows
			frame = {2'b11, cur_a, 2'b11, cur_b, 2'b11};
			adc_miso = frame[ADC_FRAME-1];
			conv_cycle = cycle;
			convs = convs + 1;
		end else if (adc_sck_q && !adc_sck) begin
			frame = {frame[ADC_FRAME-2:0], 1'b0};
			adc_miso = frame[ADC_FRAME-1];
		end
		if (sample_done) begin
			assert (convs > 0 && cycle - conv_cycle == DONE_AFTER_CONV)
				else report_error($sformatf("sample_done %0d cycles after adc_conv",
					cycle - conv_cycle));
			led_exp = led_choice(sw, cur_a, cur_b, exp_rx);
			sw_at_done = sw;
			check_pending = 1'b1;
		end
	endtask

	//////////////////////////////
	// per cycle tick
	//////////////////////////////
	always @(posedge CLK50MHZ) begin
		#2;
		cycle = cycle + 1;
		if (cycle == RST_CYCLES) begin
			RST = 1'b0;
			draw_switch();
		end
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d of %0d samples checked",
				cycle, checked, N_SAMPLES);
			stop_run();
		end
		if (cycle <= RST_CYCLES + 1) begin
			check_reset_state();
		end
		preamp_model();
		adc_model();
		cs_q = amp_cs;
		sck_q = amp_sck;
		adc_sck_q = adc_sck;
		conv_q = adc_conv;
	end

	initial begin
		wait (checked == N_SAMPLES);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* acq.f */
logic/acq_pkg.sv
logic/sample_timer.sv
logic/preamp_spi.sv
logic/adc_spi.sv
logic/acq_ctrl.sv
logic/acq_top.sv
verif/acq_props.sv
verif/acq_tb.sv

/* run.sh */
#!/bin/sh
# build and run the acquisition front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f acq.f --top-module acq_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vacq_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

echo "simulation finished with status 0"
exit 0
